// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    localparam int data_w = 8;
    localparam int addr_w = 16;

    // Opcode class in [7:6] and fields in [5:3] and [2:0]
    localparam int cls_w = 2;
    localparam int fld_w = 3;

    typedef logic [data_w-1:0] byte_t;
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [fld_w-1:0]  reg_idx_t;

    localparam reg_idx_t reg_b   = 3'd0;
    localparam reg_idx_t reg_c   = 3'd1;
    localparam reg_idx_t reg_d   = 3'd2;
    localparam reg_idx_t reg_e   = 3'd3;
    localparam reg_idx_t reg_h   = 3'd4;
    localparam reg_idx_t reg_l   = 3'd5;
    localparam reg_idx_t reg_mem = 3'd6;  // Marks (HL) with no storage behind it
    localparam reg_idx_t reg_a   = 3'd7;

    localparam logic [cls_w-1:0] cls_misc = 2'b00;  // NOP, LD r,n
    localparam logic [cls_w-1:0] cls_ld   = 2'b01;  // LD r,r', HALT
    localparam logic [cls_w-1:0] cls_alu  = 2'b10;  // ALU r
    localparam logic [cls_w-1:0] cls_ctl  = 2'b11;  // ALU n, JP

    // Low field of LD r,n and ALU n
    localparam logic [fld_w-1:0] fld_imm = 3'b110;

    localparam byte_t op_nop        = 8'h00;
    localparam byte_t op_halt       = 8'h76;
    localparam byte_t op_jp         = 8'hc3;
    localparam byte_t op_jp_cc_mask = 8'he7;  // 110cc010
    localparam byte_t op_jp_cc_pat  = 8'hc2;

    // Same order as opcode bits 5..3
    typedef enum logic [2:0] {
        alu_add,
        alu_adc,
        alu_sub,
        alu_sbc,
        alu_and,
        alu_xor,
        alu_or,
        alu_cp
    } alu_op_e;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    typedef struct packed {
        addr_t addr;
        byte_t wdata;
        logic  read_n;
        logic  write_n;
    } bus_req_t;

    typedef enum logic [1:0] {addr_pc, addr_hl} addr_sel_e;
    typedef enum logic {alu_b_reg, alu_b_imm} alu_b_sel_e;
    typedef enum logic [1:0] {rf_from_bus, rf_from_alu, rf_from_rd2, rf_from_imm} rf_data_sel_e;
    typedef enum logic {flag_src_alu, flag_src_hold} flag_src_e;
    typedef enum logic [1:0] {pc_hold, pc_inc, pc_jump} pc_sel_e;

    // Zero value means idle with no strobes or writes and PC held
    typedef struct packed {
        addr_sel_e    addr_sel;
        logic         read;
        logic         write;
        logic         imm_lo_en;
        logic         imm_hi_en;
        reg_idx_t     rd1;
        reg_idx_t     rd2;
        reg_idx_t     wr_idx;
        logic         wr_en;
        rf_data_sel_e rf_data_sel;
        alu_b_sel_e   alu_b_sel;
        alu_op_e      alu_op;
        logic         flag_wr;
        pc_sel_e      pc_sel;
    } ctrl_t;

endpackage

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  byte_t   a,
    input  byte_t   b,
    input  alu_op_e op,
    input  logic    carry_in,
    output byte_t   result,
    output flags_t  flags_out
);

    logic       cin;
    logic [4:0] half;  // Bit 4 is carry/borrow out of bit 3
    logic [8:0] full;
    logic       is_sub;

    assign is_sub = (op == alu_sub) || (op == alu_sbc) || (op == alu_cp);
    assign cin = ((op == alu_adc) || (op == alu_sbc)) && carry_in;

    always_comb
    begin
        if (is_sub)
        begin
            half = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
            full = {1'b0, a} - {1'b0, b} - {8'd0, cin};
        end
        else
        begin
            half = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
            full = {1'b0, a} + {1'b0, b} + {8'd0, cin};
        end

        result = full[7:0];
        flags_out.h = half[4];
        flags_out.c = full[8];
        case (op)
            alu_and:
            begin
                result = a & b;
                flags_out.h = 1'b1;
                flags_out.c = 1'b0;
            end
            alu_xor:
            begin
                result = a ^ b;
                flags_out.h = 1'b0;
                flags_out.c = 1'b0;
            end
            alu_or:
            begin
                result = a | b;
                flags_out.h = 1'b0;
                flags_out.c = 1'b0;
            end
            default: ;  // Arithmetic result already set
        endcase
        flags_out.z = (result == '0);
        flags_out.n = is_sub;
    end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic     clock,
    input  reg_idx_t rd1_idx,
    input  reg_idx_t rd2_idx,
    input  reg_idx_t wr_idx,
    input  logic     wr_en,
    input  byte_t    wdata,
    output byte_t    rd1,
    output byte_t    rd2,
    output addr_t    hl
);

    byte_t regs [0:7];  // Entry 6 is never written

    always_ff @(posedge clock)
    begin
        if (wr_en)
            regs[wr_idx] <= wdata;
    end

    assign rd1 = regs[rd1_idx];
    assign rd2 = regs[rd2_idx];
    assign hl = {regs[reg_h], regs[reg_l]};

endmodule

// ==== verilog/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit import cpu_pkg::*; (
    input  logic    clock,
    input  logic    rst,
    input  pc_sel_e sel,
    input  addr_t   jump_target,
    output addr_t   pc
);

    addr_t pc_next;

    always_comb
    begin
        case (sel)
            pc_inc:  pc_next = pc + addr_t'(1);
            pc_jump: pc_next = jump_target;
            default: pc_next = pc;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (rst)
            pc <= '0;  // Execution starts at 0000h
        else
            pc <= pc_next;
    end

endmodule

// ==== verilog/flag_reg.sv ====
`timescale 1ns/1ps

module flag_reg import cpu_pkg::*; (
    input  logic   clock,
    input  logic   rst,
    input  logic   wr_en,
    input  flags_t alu_flags,
    output flags_t flags
);

    flags_t flags_next;

    // All four flags follow the ALU together
    always_comb
    begin
        if (wr_en)
            flags_next = alu_flags;
        else
            flags_next = flags;
    end

    always_ff @(posedge clock)
    begin
        if (rst)
            flags <= '0;
        else
            flags <= flags_next;
    end

endmodule

// ==== verilog/bus_unit.sv ====
`timescale 1ns/1ps

module bus_unit import cpu_pkg::*; (
    input  logic     clock,
    input  logic     rst,
    input  ctrl_t    ctrl,
    input  byte_t    rdata,
    input  byte_t    rd1,
    input  byte_t    rd2,
    input  byte_t    alu_result,
    input  addr_t    hl,
    input  addr_t    pc,
    output bus_req_t bus,
    output byte_t    alu_a,
    output byte_t    alu_b,
    output byte_t    rf_wdata,
    output addr_t    jump_target
);

    byte_t imm_lo;
    byte_t imm_hi;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            imm_lo <= '0;
            imm_hi <= '0;
        end
        else
        begin
            if (ctrl.imm_lo_en)
                imm_lo <= rdata;
            if (ctrl.imm_hi_en)
                imm_hi <= rdata;
        end
    end

    assign jump_target = {imm_hi, imm_lo};

    always_comb
    begin
        bus.addr = (ctrl.addr_sel == addr_hl) ? hl : pc;
        bus.wdata = rd1;  // Stores take the source on port 1
        bus.read_n = !ctrl.read;
        bus.write_n = !ctrl.write;
    end

    assign alu_a = rd1;
    assign alu_b = (ctrl.alu_b_sel == alu_b_imm) ? imm_lo : rd2;

    always_comb
    begin
        case (ctrl.rf_data_sel)
            rf_from_bus: rf_wdata = rdata;
            rf_from_alu: rf_wdata = alu_result;
            rf_from_rd2: rf_wdata = rd2;
            default:     rf_wdata = imm_lo;
        endcase
    end

endmodule

// ==== verilog/control_unit.sv ====
`timescale 1ns/1ps

module control_unit import cpu_pkg::*; (
    input  logic   clock,
    input  logic   rst,
    input  byte_t  rdata,
    input  flags_t flags,
    output ctrl_t  ctrl
);

    byte_t            ir;
    logic [1:0]       step;
    logic             run;     // Low in the first cycle after reset
    logic             halted;
    logic             active;
    logic             last;
    logic             halt_now;
    logic             do_alu;
    logic             cond_ok;
    logic             take;
    flag_src_e        flag_src;
    logic [cls_w-1:0] cls;
    reg_idx_t         dst;
    reg_idx_t         src;

    assign active = run && !halted;
    assign cls = ir[7:6];
    assign dst = ir[5:3];
    assign src = ir[2:0];

    // NZ, Z, NC, C
    always_comb
    begin
        case (ir[4:3])
            2'b00: cond_ok = !flags.z;
            2'b01: cond_ok = flags.z;
            2'b10: cond_ok = !flags.c;
            default: cond_ok = flags.c;
        endcase
    end

    assign take = (ir == op_jp) || cond_ok;

    always_comb
    begin
        ctrl = '0;
        flag_src = flag_src_hold;
        last = 1'b1;
        halt_now = 1'b0;
        do_alu = 1'b0;
        if (active && step == 2'd0)
        begin
            ctrl.read = 1'b1;  // Opcode fetch at PC
            ctrl.pc_sel = pc_inc;
            last = 1'b0;
        end
        else if (active)
        begin
            case (cls)
                cls_misc:
                    if (src == fld_imm && dst != reg_mem)
                    begin
                        if (step == 2'd1)
                        begin
                            ctrl.read = 1'b1;
                            ctrl.imm_lo_en = 1'b1;
                            ctrl.pc_sel = pc_inc;
                            last = 1'b0;
                        end
                        else
                        begin
                            ctrl.wr_idx = dst;
                            ctrl.wr_en = 1'b1;
                            ctrl.rf_data_sel = rf_from_imm;
                        end
                    end
                cls_ld:
                    if (ir == op_halt)
                        halt_now = 1'b1;
                    else if (src == reg_mem)
                    begin
                        ctrl.addr_sel = addr_hl;  // LD r,(HL)
                        ctrl.read = 1'b1;
                        ctrl.rf_data_sel = rf_from_bus;
                        ctrl.wr_idx = dst;
                        ctrl.wr_en = 1'b1;
                    end
                    else if (dst == reg_mem)
                    begin
                        ctrl.addr_sel = addr_hl;  // LD (HL),r
                        ctrl.write = 1'b1;
                        ctrl.rd1 = src;
                    end
                    else
                    begin
                        ctrl.rd2 = src;
                        ctrl.rf_data_sel = rf_from_rd2;
                        ctrl.wr_idx = dst;
                        ctrl.wr_en = 1'b1;
                    end
                cls_alu:
                    if (src != reg_mem)
                    begin
                        do_alu = 1'b1;
                        ctrl.rd2 = src;
                    end
                default:
                    if (src == fld_imm)
                    begin
                        if (step == 2'd1)
                        begin
                            ctrl.read = 1'b1;
                            ctrl.imm_lo_en = 1'b1;
                            ctrl.pc_sel = pc_inc;
                            last = 1'b0;
                        end
                        else
                        begin
                            do_alu = 1'b1;
                            ctrl.alu_b_sel = alu_b_imm;
                        end
                    end
                    else if (ir == op_jp || (ir & op_jp_cc_mask) == op_jp_cc_pat)
                    begin
                        if (step != 2'd3)
                        begin
                            ctrl.read = 1'b1;  // Low byte, then high byte
                            ctrl.imm_lo_en = (step == 2'd1);
                            ctrl.imm_hi_en = (step == 2'd2);
                            ctrl.pc_sel = pc_inc;
                            last = 1'b0;
                        end
                        else
                            ctrl.pc_sel = take ? pc_jump : pc_hold;
                    end
            endcase
        end

        if (do_alu)
        begin
            ctrl.rd1 = reg_a;
            ctrl.alu_op = alu_op_e'(dst);
            ctrl.rf_data_sel = rf_from_alu;
            ctrl.wr_idx = reg_a;
            ctrl.wr_en = (alu_op_e'(dst) != alu_cp);  // CP only sets flags
            flag_src = flag_src_alu;
        end
        ctrl.flag_wr = (flag_src == flag_src_alu);
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            run <= 1'b0;
            halted <= 1'b0;
            step <= 2'd0;
        end
        else
        begin
            run <= 1'b1;
            if (halt_now)
                halted <= 1'b1;
            if (active)
                step <= last ? 2'd0 : step + 2'd1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (active && step == 2'd0)
            ir <= rdata;
    end

endmodule

// ==== verilog/core_top.sv ====
`timescale 1ns/1ps

module core_top import cpu_pkg::*; (
    input  logic     clock,
    input  logic     rst,
    input  byte_t    rdata,
    output bus_req_t bus
);

    ctrl_t  ctrl;
    flags_t flags;
    flags_t alu_flags;
    byte_t  rd1;
    byte_t  rd2;
    byte_t  alu_a;
    byte_t  alu_b;
    byte_t  alu_result;
    byte_t  rf_wdata;
    addr_t  hl;
    addr_t  pc;
    addr_t  jump_target;

    control_unit u_control (
        .clock (clock),
        .rst   (rst),
        .rdata (rdata),
        .flags (flags),
        .ctrl  (ctrl)
    );

    bus_unit u_bus (
        .clock       (clock),
        .rst         (rst),
        .ctrl        (ctrl),
        .rdata       (rdata),
        .rd1         (rd1),
        .rd2         (rd2),
        .alu_result  (alu_result),
        .hl          (hl),
        .pc          (pc),
        .bus         (bus),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .rf_wdata    (rf_wdata),
        .jump_target (jump_target)
    );

    reg_file u_regs (
        .clock   (clock),
        .rd1_idx (ctrl.rd1),
        .rd2_idx (ctrl.rd2),
        .wr_idx  (ctrl.wr_idx),
        .wr_en   (ctrl.wr_en),
        .wdata   (rf_wdata),
        .rd1     (rd1),
        .rd2     (rd2),
        .hl      (hl)
    );

    alu u_alu (
        .a         (alu_a),
        .b         (alu_b),
        .op        (ctrl.alu_op),
        .carry_in  (flags.c),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    flag_reg u_flags (
        .clock     (clock),
        .rst       (rst),
        .wr_en     (ctrl.flag_wr),
        .alu_flags (alu_flags),
        .flags     (flags)
    );

    pc_unit u_pc (
        .clock       (clock),
        .rst         (rst),
        .sel         (ctrl.pc_sel),
        .jump_target (jump_target),
        .pc          (pc)
    );

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clock,
    output logic rst
);

    localparam int reset_cycles = 2;

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;  // 20 ns period
    end

    initial
    begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        rst <= 1'b0;
    end

endmodule

// ==== verification/tb_core.sv ====
`timescale 1ns/1ps

module tb_core import cpu_pkg::*; ();

    localparam logic [31:0] lcg_seed = 32'hcf60_bde7;
    localparam int mem_size = 65536;
    localparam int n_blocks = 12;
    localparam int max_accesses = 4000;  // Bound for the reference model
    localparam int halt_timeout = 20000;
    localparam int quiet_cycles = 50;

    typedef struct packed {
        logic  is_write;
        addr_t addr;
        byte_t data;
    } access_t;

    typedef access_t access_q_t[$];

    logic        clock;
    logic        rst;
    byte_t       rdata;
    bus_req_t    bus;
    byte_t       image [0:mem_size-1];    // Program as generated
    byte_t       mem [0:mem_size-1];      // Memory seen by the core
    byte_t       ref_mem [0:mem_size-1];  // Working copy of the reference model
    logic [31:0] lcg_state;
    int          wp;
    int          post_reset;
    access_q_t   exp_q;

    tb_clock clock_gen (
        .clock (clock),
        .rst   (rst)
    );

    core_top uut (
        .clock (clock),
        .rst   (rst),
        .rdata (rdata),
        .bus   (bus)
    );

    always @(posedge clock)
    begin
        if (rst)
            mem <= image;
        else if (!bus.write_n)
            mem[bus.addr] <= bus.wdata;
    end

    assign rdata = bus.read_n ? 8'hff : mem[bus.addr];

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:16]) % n;
    endfunction

    function automatic byte_t rand_byte();
        logic [31:0] r;
        r = lcg_next();
        return r[31:24];
    endfunction

    // Destinations never include H or L, so HL stays in the data region
    function automatic reg_idx_t pick_dst();
        int v;
        v = rand_below(5);
        return (v == 4) ? reg_a : reg_idx_t'(v);
    endfunction

    function automatic reg_idx_t pick_src();
        int v;
        v = rand_below(7);
        return (v == 6) ? reg_a : reg_idx_t'(v);
    endfunction

    task automatic emit(input byte_t b);
        image[wp] = b;
        wp = wp + 1;
    endtask

    task automatic emit_random_instr();
        int       kind;
        reg_idx_t d;
        reg_idx_t s;
        logic [2:0] op3;
        kind = rand_below(8);
        d = pick_dst();
        s = pick_src();
        op3 = 3'(rand_below(8));
        case (kind)
            0: emit({2'b01, d, s});
            1:
            begin
                emit({2'b00, d, 3'b110});  // LD r,n
                emit(rand_byte());
            end
            2: emit({2'b01, d, reg_mem});
            3: emit({2'b01, reg_mem, s});
            4, 5: emit({2'b10, op3, s});
            6:
            begin
                emit({2'b11, op3, 3'b110});  // ALU n
                emit(rand_byte());
            end
            default: emit(op_nop);
        endcase
    endtask

    task automatic build_program();
        reg_idx_t seeds [5];
        reg_idx_t stores [7];
        int       n;
        int       jp_at;
        addr_t    target;
        logic [1:0] cc;
        seeds = '{reg_b, reg_c, reg_d, reg_e, reg_a};
        stores = '{reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_a};
        for (int a = 0; a < mem_size; a++)
            image[a] = byte_t'(a ^ (a >> 8)) ^ 8'h3c;
        wp = 0;
        emit({2'b00, reg_h, 3'b110});
        emit(8'h80 | (rand_byte() & 8'h3f));  // HL in 8000h..BFFFh
        emit({2'b00, reg_l, 3'b110});
        emit(rand_byte());
        foreach (seeds[i])
        begin
            emit({2'b00, seeds[i], 3'b110});
            emit(rand_byte());
        end
        for (int blk = 0; blk < n_blocks; blk++)
        begin
            n = 3 + rand_below(5);
            for (int i = 0; i < n; i++)
                emit_random_instr();
            jp_at = wp;
            wp = wp + 3;
            n = 1 + rand_below(3);  // Runs only when the jump is not taken
            for (int i = 0; i < n; i++)
                emit_random_instr();
            target = addr_t'(wp);
            cc = 2'(rand_below(4));
            image[jp_at] = (rand_below(4) == 0) ? op_jp : {3'b110, cc, 3'b010};
            image[jp_at + 1] = target[7:0];
            image[jp_at + 2] = target[15:8];
        end
        foreach (stores[i])
            emit({2'b01, reg_mem, stores[i]});
        emit(op_halt);
    endtask

    function automatic byte_t alu_ref(input logic [2:0] op, input byte_t a, input byte_t b,
                                      input flags_t f_in, output flags_t f_out);
        int    ci;
        int    sum;
        int    low;
        byte_t res;
        ci = ((op == 3'd1 || op == 3'd3) && f_in.c) ? 1 : 0;
        f_out = '0;
        case (op)
            3'd0, 3'd1:
            begin
                sum = int'(a) + int'(b) + ci;
                low = int'(a) % 16 + int'(b) % 16 + ci;
                res = byte_t'(sum);
                f_out.h = (low > 15);
                f_out.c = (sum > 255);
            end
            3'd4:
            begin
                res = a & b;
                f_out.h = 1'b1;
            end
            3'd5: res = a ^ b;
            3'd6: res = a | b;
            default:
            begin
                sum = int'(a) - int'(b) - ci;  // sub, sbc and cp
                low = int'(a) % 16 - int'(b) % 16 - ci;
                res = byte_t'(sum);
                f_out.h = (low < 0);
                f_out.c = (sum < 0);
                f_out.n = 1'b1;
            end
        endcase
        f_out.z = (res == 8'h00);
        return res;
    endfunction

    function automatic access_t make_access(input logic is_write, input addr_t addr,
                                            input byte_t data);
        access_t x;
        x.is_write = is_write;
        x.addr = addr;
        x.data = data;
        return x;
    endfunction

    function automatic access_q_t interpret();
        access_q_t acc;
        byte_t     r [0:7];
        byte_t     res;
        byte_t     lo;
        flags_t    f;
        flags_t    f_new;
        addr_t     pc;
        addr_t     hl;
        byte_t     op;
        logic      done;
        logic      cond;
        for (int a = 0; a < mem_size; a++)
            ref_mem[a] = image[a];
        for (int i = 0; i < 8; i++)
            r[i] = '0;
        f = '0;
        pc = '0;
        done = 1'b0;
        while (!done && acc.size() < max_accesses)
        begin
            op = ref_mem[pc];
            acc.push_back(make_access(1'b0, pc, 8'h00));
            pc = pc + 16'd1;
            hl = {r[4], r[5]};
            case (op[7:6])
                2'b00:
                    if (op[2:0] == 3'd6 && op[5:3] != 3'd6)
                    begin
                        acc.push_back(make_access(1'b0, pc, 8'h00));
                        r[op[5:3]] = ref_mem[pc];
                        pc = pc + 16'd1;
                    end
                2'b01:
                    if (op == 8'h76)
                        done = 1'b1;
                    else if (op[2:0] == 3'd6)
                    begin
                        acc.push_back(make_access(1'b0, hl, 8'h00));
                        r[op[5:3]] = ref_mem[hl];
                    end
                    else if (op[5:3] == 3'd6)
                    begin
                        acc.push_back(make_access(1'b1, hl, r[op[2:0]]));
                        ref_mem[hl] = r[op[2:0]];
                    end
                    else
                        r[op[5:3]] = r[op[2:0]];
                2'b10:
                    if (op[2:0] != 3'd6)
                    begin
                        res = alu_ref(op[5:3], r[7], r[op[2:0]], f, f_new);
                        f = f_new;
                        if (op[5:3] != 3'd7)
                            r[7] = res;
                    end
                default:
                    if (op[2:0] == 3'd6)
                    begin
                        acc.push_back(make_access(1'b0, pc, 8'h00));
                        res = alu_ref(op[5:3], r[7], ref_mem[pc], f, f_new);
                        pc = pc + 16'd1;
                        f = f_new;
                        if (op[5:3] != 3'd7)
                            r[7] = res;
                    end
                    else if (op == 8'hc3 || (op & 8'he7) == 8'hc2)
                    begin
                        acc.push_back(make_access(1'b0, pc, 8'h00));
                        lo = ref_mem[pc];
                        pc = pc + 16'd1;
                        acc.push_back(make_access(1'b0, pc, 8'h00));
                        case (op[4:3])
                            2'b00: cond = !f.z;
                            2'b01: cond = f.z;
                            2'b10: cond = !f.c;
                            default: cond = f.c;
                        endcase
                        if (op == 8'hc3 || cond)
                            pc = {ref_mem[pc], lo};
                        else
                            pc = pc + 16'd1;
                    end
            endcase
        end
        return acc;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped on a failed check");
    endtask

    task automatic check_idle(input bus_req_t b, input string when);
        if (!b.read_n || !b.write_n)
            stop_with_error($sformatf("A bus strobe was low %s", when));
    endtask

    task automatic check_read(input addr_t addr);
        access_t e;
        if (exp_q.size() == 0)
            stop_with_error($sformatf("The core read from %h after HALT", addr));
        else
        begin
            e = exp_q.pop_front();
            if (e.is_write || e.addr != addr)
                stop_with_error($sformatf("[ERROR] %0t: read at %h, expected %s at %h",
                    $time, addr, e.is_write ? "write" : "read", e.addr));
        end
    endtask

    task automatic check_write(input addr_t addr, input byte_t data);
        access_t e;
        if (exp_q.size() == 0)
            stop_with_error($sformatf("The core wrote to %h after HALT", addr));
        else
        begin
            e = exp_q.pop_front();
            if (!e.is_write || e.addr != addr || e.data != data)
                stop_with_error($sformatf("[ERROR] %0t: write %h at %h, expected %s %h at %h",
                    $time, data, addr, e.is_write ? "write" : "read", e.data, e.addr));
        end
    endtask

    // Bus is sampled mid-cycle away from the edges
    always @(negedge clock)
    begin
        if (rst)
        begin
            post_reset = 0;
            check_idle(bus, "during reset");
        end
        else if (post_reset == 0)
        begin
            post_reset = 1;
            check_idle(bus, "in the cycle after reset");
        end
        else
        begin
            if (!bus.read_n && !bus.write_n)
                stop_with_error("Read and write strobes were low in the same cycle");
            else
            begin
                if (!bus.read_n)
                    check_read(bus.addr);
                if (!bus.write_n)
                    check_write(bus.addr, bus.wdata);
            end
        end
    end

    initial
    begin
        int cycles;
        lcg_state = lcg_seed;
        post_reset = 0;
        build_program();
        exp_q = interpret();
        if (exp_q.size() >= max_accesses)
            stop_with_error("The program did not run to HALT in the reference model");
        else
        begin
            cycles = 0;
            while (exp_q.size() != 0 && cycles < halt_timeout)
            begin
                @(posedge clock);
                cycles++;
            end
            if (exp_q.size() != 0)
                stop_with_error("Timeout: the core never reached the HALT fetch");
            else
            begin
                repeat (quiet_cycles) @(posedge clock);  // Any access here fails in the checker
                $display("Done: no errors");
                $finish;
            end
        end
    end

endmodule

// ==== build.f ====
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/pc_unit.sv
verilog/flag_reg.sv
verilog/bus_unit.sv
verilog/control_unit.sv
verilog/core_top.sv
verification/tb_clock.sv
verification/tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= tb_core
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
